//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = fc_layer_tb
FILELIST  = all.f
BUILD_DIR = obj_dir
SIM_BIN   = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(wildcard source/*.sv source/*.svh test/*.sv)

.PHONY: all run check clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@! grep -q "SIMULATION FAILED" $(LOG)

check:
	@! grep -q "SIMULATION FAILED" $(LOG) && grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
+incdir+source
source/fc_types_pkg.sv
source/fc_ctrl_pkg.sv
source/param_loader.sv
source/weight_bank.sv
source/fc_sequencer.sv
source/mac_array.sv
source/fc_layer_top.sv
test/fc_layer_tb.sv

//--- source/fc_consts.svh
`ifndef FC_CONSTS_SVH
`define FC_CONSTS_SVH

// ************************************************************
// layer geometry and datapath width.
// ************************************************************
`define FC_DATA_WIDTH 32
`define FC_IN_COUNT   84   // activations per pass.
`define FC_OUT_COUNT  10   // neurons.

`define FC_ROW_BITS   7
`define FC_BANK_BITS  4

// host address is {region, bank, row}.
`define FC_ADDR_BITS  12
`define FC_BANK_LSB   7
`define FC_REGION_BIT 11

`endif

//--- source/fc_ctrl_pkg.sv
package fc_ctrl_pkg;

    // sequencer states, also used as the mac step command.
    typedef enum logic [1:0]
    {
        s_idle  = 2'd0,
        s_accum = 2'd1,
        s_bias  = 2'd2,
        s_done  = 2'd3
    } seq_state_t;

    // top bit of the host address.
    typedef enum logic
    {
        region_weight = 1'b0,
        region_bias   = 1'b1
    } region_t;

endpackage

//--- source/fc_layer_top.sv
`timescale 1ns/10ps
`include "fc_consts.svh"

module fc_layer_top
(
    input  logic                        clk,
    input  logic                        reset,
    // host parameter writes.
    input  logic                        host_wr_valid,
    input  logic [`FC_ADDR_BITS-1:0]    host_wr_addr,
    input  fc_types_pkg::word_t         host_wr_data,
    output logic                        host_wr_ready,
    // activation stream.
    input  logic                        act_valid,
    input  fc_types_pkg::word_t         act_data,
    output logic                        act_ready,
    // results.
    output logic                        result_valid,
    output fc_types_pkg::word_vec_t     result_data,
    input  logic                        result_ready
);

    logic                          busy;
    logic [`FC_OUT_COUNT-1:0]      wr_en;
    fc_types_pkg::row_t            wr_row;
    fc_types_pkg::word_t           wr_data;
    fc_types_pkg::word_vec_t       bias_vec;
    fc_types_pkg::row_t            rd_row;
    fc_types_pkg::word_vec_t       weight_row;
    fc_types_pkg::word_t           act_q;
    fc_ctrl_pkg::seq_state_t       mac_step;

    param_loader u_param_loader
    (
        .clk           (clk),
        .reset         (reset),
        .host_wr_valid (host_wr_valid),
        .host_wr_addr  (host_wr_addr),
        .host_wr_data  (host_wr_data),
        .busy          (busy),
        .host_wr_ready (host_wr_ready),
        .wr_en         (wr_en),
        .wr_row        (wr_row),
        .wr_data       (wr_data),
        .bias_vec      (bias_vec)
    );

    weight_bank u_weight_bank
    (
        .clk        (clk),
        .wr_en      (wr_en),
        .wr_row     (wr_row),
        .wr_data    (wr_data),
        .rd_row     (rd_row),
        .weight_row (weight_row)
    );

    fc_sequencer u_fc_sequencer
    (
        .clk          (clk),
        .reset        (reset),
        .act_valid    (act_valid),
        .act_data     (act_data),
        .result_ready (result_ready),
        .act_ready    (act_ready),
        .rd_row       (rd_row),
        .act_q        (act_q),
        .mac_step     (mac_step),
        .busy         (busy),
        .result_valid (result_valid)
    );

    mac_array u_mac_array
    (
        .clk         (clk),
        .reset       (reset),
        .mac_step    (mac_step),
        .act_q       (act_q),
        .weight_row  (weight_row),
        .bias_vec    (bias_vec),
        .result_data (result_data)
    );

endmodule

//--- source/fc_sequencer.sv
`timescale 1ns/10ps
`include "fc_consts.svh"

module fc_sequencer
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        act_valid,
    input  fc_types_pkg::word_t         act_data,
    input  logic                        result_ready,
    output logic                        act_ready,
    output fc_types_pkg::row_t          rd_row,
    output fc_types_pkg::word_t         act_q,
    output fc_ctrl_pkg::seq_state_t     mac_step,
    output logic                        busy,
    output logic                        result_valid
);

    fc_ctrl_pkg::seq_state_t  state;
    fc_types_pkg::row_t       count;
    fc_types_pkg::word_t      act_raw;
    logic                     act_fire;
    logic                     last_act;
    logic                     fire_d;

    assign act_ready    = (state == fc_ctrl_pkg::s_idle) || (state == fc_ctrl_pkg::s_accum);
    assign busy         = (state != fc_ctrl_pkg::s_idle);
    assign result_valid = (state == fc_ctrl_pkg::s_done);

    assign act_fire = act_valid && act_ready;
    assign last_act = (count == fc_types_pkg::row_t'(`FC_IN_COUNT - 1));

    // ************************************************************
    // pass state and input index.
    // ************************************************************
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= fc_ctrl_pkg::s_idle;
            count <= '0;
        end
        else
        begin
            case (state)
                fc_ctrl_pkg::s_idle, fc_ctrl_pkg::s_accum:
                begin
                    if (act_fire)
                    begin
                        if (last_act)
                        begin
                            state <= fc_ctrl_pkg::s_bias;
                            count <= '0;
                        end
                        else
                        begin
                            state <= fc_ctrl_pkg::s_accum;
                            count <= count + 1'b1;
                        end
                    end
                end
                fc_ctrl_pkg::s_bias:
                begin
                    // bias lands on the edge that raises result_valid.
                    if (mac_step == fc_ctrl_pkg::s_bias)
                    begin
                        state <= fc_ctrl_pkg::s_done;
                    end
                end
                default:
                begin
                    if (result_ready)
                    begin
                        state <= fc_ctrl_pkg::s_idle;
                    end
                end
            endcase
        end
    end

    // ************************************************************
    // mac step command, two edges behind acceptance.
    // ************************************************************
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            fire_d   <= 1'b0;
            mac_step <= fc_ctrl_pkg::s_idle;
        end
        else
        begin
            fire_d <= act_fire;
            if (fire_d)
                mac_step <= fc_ctrl_pkg::s_accum;
            else if ((state == fc_ctrl_pkg::s_bias) && (mac_step == fc_ctrl_pkg::s_accum))
                mac_step <= fc_ctrl_pkg::s_bias; // right after the last product.
            else if (result_valid && result_ready)
                mac_step <= fc_ctrl_pkg::s_done; // clear for the next pass.
            else
                mac_step <= fc_ctrl_pkg::s_idle;
        end
    end

    // activation and read index, then relu.
    always_ff @(posedge clk)
    begin
        if (act_fire)
        begin
            act_raw <= act_data;
            rd_row  <= count;
        end
        if (fire_d)
        begin
            act_q <= act_raw[`FC_DATA_WIDTH-1] ? '0 : act_raw;
        end
    end

endmodule

//--- source/fc_types_pkg.sv
`include "fc_consts.svh"

package fc_types_pkg;

    // one signed data word, wraps modulo 2^32.
    typedef logic signed [`FC_DATA_WIDTH-1:0] word_t;

    // one word per neuron.
    typedef word_t [`FC_OUT_COUNT-1:0] word_vec_t;

    typedef logic [`FC_ROW_BITS-1:0] row_t;   // input index.
    typedef logic [`FC_BANK_BITS-1:0] bank_t; // neuron index.

endpackage

//--- source/mac_array.sv
`timescale 1ns/10ps
`include "fc_consts.svh"

module mac_array
(
    input  logic                        clk,
    input  logic                        reset,
    input  fc_ctrl_pkg::seq_state_t     mac_step,
    input  fc_types_pkg::word_t         act_q,
    input  fc_types_pkg::word_vec_t     weight_row,
    input  fc_types_pkg::word_vec_t     bias_vec,
    output fc_types_pkg::word_vec_t     result_data
);

    fc_types_pkg::word_vec_t prod;

    // ************************************************************
    // products, low 32 bits kept.
    // ************************************************************
    always_comb
    begin
        for (int i = 0; i < `FC_OUT_COUNT; i++)
        begin
            prod[i] = act_q * weight_row[i];
        end
    end

    // ************************************************************
    // accumulators double as result registers.
    // ************************************************************
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            result_data <= '0;
        end
        else
        begin
            case (mac_step)
                fc_ctrl_pkg::s_accum:
                begin
                    for (int i = 0; i < `FC_OUT_COUNT; i++)
                    begin
                        result_data[i] <= result_data[i] + prod[i];
                    end
                end
                fc_ctrl_pkg::s_bias:
                begin
                    for (int i = 0; i < `FC_OUT_COUNT; i++)
                    begin
                        result_data[i] <= result_data[i] + bias_vec[i];
                    end
                end
                fc_ctrl_pkg::s_done:
                begin
                    result_data <= '0; // result taken.
                end
                default:
                begin
                    result_data <= result_data; // hold, also while stalled.
                end
            endcase
        end
    end

endmodule

//--- source/param_loader.sv
`timescale 1ns/10ps
`include "fc_consts.svh"

module param_loader
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          host_wr_valid,
    input  logic [`FC_ADDR_BITS-1:0]      host_wr_addr,
    input  fc_types_pkg::word_t           host_wr_data,
    input  logic                          busy,
    output logic                          host_wr_ready,
    output logic [`FC_OUT_COUNT-1:0]      wr_en,
    output fc_types_pkg::row_t            wr_row,
    output fc_types_pkg::word_t           wr_data,
    output fc_types_pkg::word_vec_t       bias_vec
);

    logic                  wr_fire;
    fc_ctrl_pkg::region_t  region;
    fc_types_pkg::bank_t   bank;
    logic                  bank_ok;
    logic                  row_ok;

    // ************************************************************
    // address decode.
    // ************************************************************
    assign host_wr_ready = !busy; // no loads during a pass.
    assign wr_fire       = host_wr_valid && host_wr_ready;

    assign region = fc_ctrl_pkg::region_t'(host_wr_addr[`FC_REGION_BIT]);
    assign bank   = host_wr_addr[`FC_BANK_LSB +: `FC_BANK_BITS];
    assign wr_row = host_wr_addr[`FC_ROW_BITS-1:0];

    assign bank_ok = (bank < `FC_OUT_COUNT);
    assign row_ok  = (wr_row < `FC_IN_COUNT);

    assign wr_data = host_wr_data;

    // one-hot write strobe into the weight memories.
    always_comb
    begin
        wr_en = '0;
        if (wr_fire && (region == fc_ctrl_pkg::region_weight) && bank_ok && row_ok)
        begin
            wr_en[bank] = 1'b1;
        end
    end

    // ************************************************************
    // bias registers.
    // ************************************************************
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            bias_vec <= '0;
        end
        else if (wr_fire && (region == fc_ctrl_pkg::region_bias) && bank_ok)
        begin
            bias_vec[bank] <= host_wr_data; // row field ignored here.
        end
    end

endmodule

//--- source/weight_bank.sv
`timescale 1ns/10ps
`include "fc_consts.svh"

module weight_bank
(
    input  logic                        clk,
    input  logic [`FC_OUT_COUNT-1:0]    wr_en,
    input  fc_types_pkg::row_t          wr_row,
    input  fc_types_pkg::word_t         wr_data,
    input  fc_types_pkg::row_t          rd_row,
    output fc_types_pkg::word_vec_t     weight_row
);

    fc_types_pkg::row_t rd_addr_q;

    // shared read address, one cycle behind rd_row.
    always_ff @(posedge clk)
    begin
        rd_addr_q <= rd_row;
    end

    // ************************************************************
    // one memory per neuron.
    // ************************************************************
    for (genvar b = 0; b < `FC_OUT_COUNT; b++)
    begin : g_bank
        fc_types_pkg::word_t mem [0:`FC_IN_COUNT-1];

        always_ff @(posedge clk)
        begin
            if (wr_en[b])
            begin
                mem[wr_row] <= wr_data;
            end
        end

        assign weight_row[b] = mem[rd_addr_q]; // weight of this neuron for the index.
    end

endmodule

//--- test/fc_layer_tb.sv
`timescale 1ns/10ps
`include "fc_consts.svh"

module fc_layer_tb;

    localparam int TIMEOUT_CYCLES = 20000; // about six times the longest run.

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      host_wr_valid;
    logic [`FC_ADDR_BITS-1:0]  host_wr_addr;
    fc_types_pkg::word_t       host_wr_data;
    logic                      host_wr_ready;
    logic                      act_valid;
    fc_types_pkg::word_t       act_data;
    logic                      act_ready;
    logic                      result_valid;
    fc_types_pkg::word_vec_t   result_data;
    logic                      result_ready;

    // reference model state.
    fc_types_pkg::word_t       shadow_w [`FC_OUT_COUNT][`FC_IN_COUNT];
    fc_types_pkg::word_t       shadow_b [`FC_OUT_COUNT];
    fc_types_pkg::word_t       acts [`FC_IN_COUNT];
    fc_types_pkg::word_vec_t   expected;
    fc_types_pkg::word_vec_t   observed;
    fc_types_pkg::word_vec_t   first_result;

    int          cycles;
    int          checks;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int unsigned seed_value;

    fc_layer_top u_dut
    (
        .clk           (clk),
        .reset         (reset),
        .host_wr_valid (host_wr_valid),
        .host_wr_addr  (host_wr_addr),
        .host_wr_data  (host_wr_data),
        .host_wr_ready (host_wr_ready),
        .act_valid     (act_valid),
        .act_data      (act_data),
        .act_ready     (act_ready),
        .result_valid  (result_valid),
        .result_data   (result_data),
        .result_ready  (result_ready)
    );

    always
    begin
        #2 clk = ~clk;
    end

    initial
    begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    // ************************************************************
    // checking and bookkeeping.
    // ************************************************************
    task automatic expect_word(input string name, input fc_types_pkg::word_t got,
                               input fc_types_pkg::word_t exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("CHECK FAILED at %0t ns: %s = %0d (0x%08h), expected %0d (0x%08h)",
                     $time, name, got, got, exp, exp);
            test_errors++;
        end
    endtask

    task automatic expect_flag(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("CHECK FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0)
        begin
            $display("test %s: ok", name);
        end
        else
        begin
            $display("test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    // ************************************************************
    // host writes and the reference model.
    // ************************************************************
    function automatic logic [`FC_ADDR_BITS-1:0] make_addr(fc_ctrl_pkg::region_t region,
                                                          int bank, int row);
        make_addr = {region, fc_types_pkg::bank_t'(bank), fc_types_pkg::row_t'(row)};
    endfunction

    task automatic host_write(input logic [`FC_ADDR_BITS-1:0] addr,
                              input fc_types_pkg::word_t data);
        int bank;
        int row;
        bank = int'(addr[`FC_BANK_LSB +: `FC_BANK_BITS]);
        row  = int'(addr[`FC_ROW_BITS-1:0]);
        host_wr_valid = 1'b1;
        host_wr_addr  = addr;
        host_wr_data  = data;
        while (host_wr_ready !== 1'b1)
        begin
            @(negedge clk);
        end
        @(negedge clk);
        host_wr_valid = 1'b0;
        if (bank < `FC_OUT_COUNT)
        begin
            if (addr[`FC_REGION_BIT] == fc_ctrl_pkg::region_bias)
                shadow_b[bank] = data; // row ignored.
            else if (row < `FC_IN_COUNT)
                shadow_w[bank][row] = data;
        end
    endtask

    task automatic load_params(input bit random_values);
        fc_types_pkg::word_t data;
        for (int n = 0; n < `FC_OUT_COUNT; n++)
        begin
            for (int i = 0; i < `FC_IN_COUNT; i++)
            begin
                data = random_values ? $urandom : (n + 1) * ((i % 7) - 3);
                host_write(make_addr(fc_ctrl_pkg::region_weight, n, i), data);
            end
        end
        for (int n = 0; n < `FC_OUT_COUNT; n++)
        begin
            data = random_values ? $urandom : 100 * n - 450;
            host_write(make_addr(fc_ctrl_pkg::region_bias, n, 0), data);
        end
    endtask

    // bias plus relu(a) times w, wrapping at 32 bits.
    task automatic compute_expected();
        fc_types_pkg::word_t acc;
        fc_types_pkg::word_t a;
        for (int n = 0; n < `FC_OUT_COUNT; n++)
        begin
            acc = shadow_b[n];
            for (int i = 0; i < `FC_IN_COUNT; i++)
            begin
                a = (acts[i] < 0) ? 0 : acts[i];
                acc = acc + a * shadow_w[n][i];
            end
            expected[n] = acc;
        end
    endtask

    // ************************************************************
    // activation stream and result handshake.
    // ************************************************************
    task automatic stream_acts(input int gap_max);
        int gap;
        for (int i = 0; i < `FC_IN_COUNT; i++)
        begin
            gap = (gap_max > 0) ? int'($urandom_range(gap_max, 0)) : 0;
            act_valid = 1'b0;
            repeat (gap) @(negedge clk);
            act_valid = 1'b1;
            act_data  = acts[i];
            while (act_ready !== 1'b1)
            begin
                @(negedge clk);
            end
            @(negedge clk);
        end
        act_valid = 1'b0;
    endtask

    task automatic collect_result(input int hold_cycles);
        fc_types_pkg::word_vec_t held;
        int waited;
        waited = 0;
        while (result_valid !== 1'b1)
        begin
            @(negedge clk);
            waited++;
            expect_flag("act_ready", act_ready, 1'b0);
            expect_flag("host_wr_ready", host_wr_ready, 1'b0);
        end
        expect_word("result_valid latency", waited, 3); // edges after the last acceptance.
        held = result_data;
        repeat (hold_cycles)
        begin
            @(negedge clk);
            expect_flag("result_valid", result_valid, 1'b1);
            expect_flag("act_ready", act_ready, 1'b0);
            expect_flag("host_wr_ready", host_wr_ready, 1'b0);
            for (int n = 0; n < `FC_OUT_COUNT; n++)
                expect_word($sformatf("result_data[%0d]", n), result_data[n], held[n]);
        end
        result_ready = 1'b1;
        observed = result_data;
        for (int n = 0; n < `FC_OUT_COUNT; n++)
            expect_word($sformatf("result_data[%0d]", n), result_data[n], expected[n]);
        @(negedge clk);
        result_ready = 1'b0;
        expect_flag("result_valid", result_valid, 1'b0);
        expect_flag("act_ready", act_ready, 1'b1);
        expect_flag("host_wr_ready", host_wr_ready, 1'b1);
    endtask

    task automatic random_acts();
        for (int i = 0; i < `FC_IN_COUNT; i++)
            acts[i] = $urandom;
    endtask

    // ************************************************************
    // directed tests.
    // ************************************************************
    task automatic reset_state_test();
        expect_flag("act_ready", act_ready, 1'b1);
        expect_flag("host_wr_ready", host_wr_ready, 1'b1);
        expect_flag("result_valid", result_valid, 1'b0);
        for (int n = 0; n < `FC_OUT_COUNT; n++)
            expect_word($sformatf("result_data[%0d]", n), result_data[n], 0);
        finish_test("reset_state");
    endtask

    task automatic small_known_test();
        load_params(1'b0);
        for (int i = 0; i < `FC_IN_COUNT; i++)
            acts[i] = i + 1;
        compute_expected();
        stream_acts(0);
        collect_result(0);
        finish_test("small_known");
    endtask

    task automatic relu_negative_test();
        for (int i = 0; i < `FC_IN_COUNT; i++)
            acts[i] = -(i * 1000 + 7);
        for (int n = 0; n < `FC_OUT_COUNT; n++)
            expected[n] = shadow_b[n]; // only the bias survives.
        stream_acts(0);
        collect_result(0);
        for (int i = 0; i < `FC_IN_COUNT; i++)
            acts[i] = (i % 2 == 1) ? i * 3 + 1 : -(i + 1) * 5000;
        compute_expected();
        stream_acts(0);
        collect_result(0);
        finish_test("relu_negative");
    endtask

    task automatic random_gap_test();
        load_params(1'b1);
        repeat (2)
        begin
            random_acts();
            acts[0] = 32'sh7fff_ffff; // extremes.
            acts[1] = 32'sh8000_0000;
            compute_expected();
            stream_acts(3);
            collect_result(0);
        end
        finish_test("random_gap");
    endtask

    task automatic stall_repeat_test();
        random_acts();
        compute_expected();
        stream_acts(0);
        collect_result(8);
        random_acts();
        compute_expected();
        stream_acts(1);
        collect_result(0);
        finish_test("stall_repeat");
    endtask

    task automatic out_of_range_test();
        random_acts();
        compute_expected();
        stream_acts(0);
        collect_result(0);
        first_result = observed;
        host_write(make_addr(fc_ctrl_pkg::region_weight, 10, 5), $urandom);
        host_write(make_addr(fc_ctrl_pkg::region_weight, 12, 0), $urandom);
        host_write(make_addr(fc_ctrl_pkg::region_weight, 15, 83), $urandom);
        host_write(make_addr(fc_ctrl_pkg::region_weight, 3, 84), $urandom);
        host_write(make_addr(fc_ctrl_pkg::region_weight, 9, 127), $urandom);
        host_write(make_addr(fc_ctrl_pkg::region_bias, 10, 0), $urandom);
        host_write(make_addr(fc_ctrl_pkg::region_bias, 15, 40), $urandom);
        compute_expected();
        stream_acts(0);
        collect_result(0);
        for (int n = 0; n < `FC_OUT_COUNT; n++)
            expect_word($sformatf("result_data[%0d]", n), observed[n], first_result[n]);
        finish_test("out_of_range");
    endtask

    // ************************************************************
    // main sequence.
    // ************************************************************
    initial
    begin
        seed_value    = $urandom(71);
        reset         = 1'b1;
        host_wr_valid = 1'b0;
        host_wr_addr  = '0;
        host_wr_data  = '0;
        act_valid     = 1'b0;
        act_data      = '0;
        result_ready  = 1'b0;
        checks        = 0;
        errors        = 0;
        test_errors   = 0;
        tests_run     = 0;
        tests_failed  = 0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        reset_state_test();
        small_known_test();
        relu_negative_test();
        random_gap_test();
        stall_repeat_test();
        out_of_range_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
